// File: hps_pkg.sv
/* host command port definitions */

`default_nettype none

package hps_pkg;

	//////////////////////////////
	// bus words
	//////////////////////////////

	typedef logic [15:0] word_t;

	// index 0 is the command word, saturates at the top
	typedef logic [9:0] word_idx_t;

	typedef logic [7:0] byte_t;

	//////////////////////////////
	// virtual disks
	//////////////////////////////

	// fixed by the layout of the sd status word
	localparam int NUM_VDISK = 2;

	typedef logic [NUM_VDISK-1:0] vdisk_t;
	typedef logic [8:0] buff_addr_t;
	typedef logic [26:0] dl_addr_t;

	// constant nibble at bits 7:4 of the sd status word
	localparam logic [3:0] SD_CMD_ID = 4'h5;

	// top nibble of the status-set reply
	localparam logic [3:0] STATUS_SET_TAG = 4'hA;

	//////////////////////////////
	// command opcodes
	//////////////////////////////

	typedef enum logic [15:0] {
		CMD_CFG         = 16'h0001,
		CMD_JOY0        = 16'h0002,
		CMD_JOY1        = 16'h0003,
		CMD_JOY_RAW     = 16'h000F,
		CMD_SD_STATUS   = 16'h0016,
		CMD_SD_WRITE    = 16'h0017,
		CMD_SD_READ     = 16'h0018,
		CMD_IMG_MOUNT   = 16'h001C,
		CMD_IMG_SIZE    = 16'h001D,
		CMD_STATUS      = 16'h001E,
		CMD_STATUS_SET  = 16'h0029,
		CMD_MENUMASK    = 16'h002E,
		CMD_FILE_TX     = 16'h0053,
		CMD_FILE_TX_DAT = 16'h0054,
		CMD_FILE_INDEX  = 16'h0055,
		CMD_FILE_INFO   = 16'h0056
	} hps_cmd_e;

endpackage

`default_nettype wire

// File: hps_frame.sv
/* transaction frame tracker */

`default_nettype none

module hps_frame (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              io_enable,
	input  logic              io_strobe,
	input  hps_pkg::word_t    io_din,
	output hps_pkg::word_t    cmd,
	output hps_pkg::word_idx_t word_idx,
	output logic              cmd_strobe,
	output logic              data_strobe,
	output logic              frame_end
);

	import hps_pkg::*;

	word_t cmd_q;
	logic  io_enable_q;

	// first strobe of a frame is the command, the rest are data
	assign cmd_strobe  = io_enable & io_strobe & (word_idx == '0);
	assign data_strobe = io_enable & io_strobe & (word_idx != '0);

	// falling edge of io_enable
	assign frame_end = io_enable_q & ~io_enable;

	// decoders see the opcode already in the command cycle
	assign cmd = cmd_strobe ? io_din : cmd_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_enable_q <= 1'b0;
			word_idx    <= '0;
			cmd_q       <= '0;
		end else begin
			io_enable_q <= io_enable;
			if (!io_enable) begin
				word_idx <= '0;
				cmd_q    <= '0;
			end else if (io_strobe) begin
				if (cmd_strobe)
					cmd_q <= io_din;
				// hold at the last index on very long frames
				if (word_idx != '1)
					word_idx <= word_idx + 10'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: user_io_regs.sv
/* user i/o registers */

`default_nettype none

module user_io_regs (
	input  logic               clk_sys,
	input  logic               reset,
	input  hps_pkg::word_t     cmd,
	input  hps_pkg::word_idx_t word_idx,
	input  logic               cmd_strobe,
	input  logic               data_strobe,
	input  logic               frame_end,
	input  hps_pkg::word_t     io_din,
	input  hps_pkg::word_t     joy_raw,
	input  logic [31:0]        status_in,
	input  logic               status_set,
	input  hps_pkg::word_t     status_menumask,
	output logic [31:0]        joystick_0,
	output logic [31:0]        joystick_1,
	output logic [31:0]        status,
	output logic [1:0]         buttons,
	output logic               forced_scandoubler,
	output hps_pkg::word_t     rd_word
);

	import hps_pkg::*;

	byte_t       cfg;
	logic        set_q1;
	logic        set_q2;
	logic [3:0]  set_cnt;
	logic [31:0] status_req;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	//////////////////////////////
	// status-set request
	//////////////////////////////

	// registered once before the edge detect, so count and data land
	// two cycles after the request rises
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			set_q1     <= 1'b0;
			set_q2     <= 1'b0;
			set_cnt    <= '0;
			status_req <= '0;
		end else begin
			set_q1 <= status_set;
			set_q2 <= set_q1;
			if (set_q1 && !set_q2) begin
				set_cnt    <= set_cnt + 4'd1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////
	// host writes and readback
	//////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			cfg        <= '0;
			rd_word    <= '0;
		end else begin
			if (cmd_strobe || data_strobe || frame_end)
				rd_word <= '0;

			if (cmd_strobe && cmd == CMD_STATUS_SET)
				rd_word <= {8'h00, STATUS_SET_TAG, set_cnt};

			if (data_strobe) begin
				case (cmd)
					CMD_CFG: if (word_idx == 10'd1) cfg <= io_din[7:0];
					CMD_JOY0: begin
						if (word_idx == 10'd1)
							joystick_0[15:0] <= io_din;
						else if (word_idx == 10'd2)
							joystick_0[31:16] <= io_din;
					end
					CMD_JOY1: begin
						if (word_idx == 10'd1)
							joystick_1[15:0] <= io_din;
						else if (word_idx == 10'd2)
							joystick_1[31:16] <= io_din;
					end
					CMD_STATUS: begin
						if (word_idx == 10'd1)
							status[15:0] <= io_din;
						else if (word_idx == 10'd2)
							status[31:16] <= io_din;
					end
					CMD_JOY_RAW: rd_word <= joy_raw;
					CMD_STATUS_SET: begin
						if (word_idx == 10'd1)
							rd_word <= status_req[15:0];
						else if (word_idx == 10'd2)
							rd_word <= status_req[31:16];
					end
					CMD_MENUMASK: if (word_idx == 10'd1) rd_word <= status_menumask;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: sd_block_io.sv
/* virtual sd block access */

`default_nettype none

module sd_block_io (
	input  logic               clk_sys,
	input  logic               reset,
	input  hps_pkg::word_t     cmd,
	input  hps_pkg::word_idx_t word_idx,
	input  logic               cmd_strobe,
	input  logic               data_strobe,
	input  logic               frame_end,
	input  hps_pkg::word_t     io_din,
	input  logic [31:0]        sd_lba,
	input  hps_pkg::vdisk_t    sd_rd,
	input  hps_pkg::vdisk_t    sd_wr,
	input  hps_pkg::word_t     sd_req_type,
	input  hps_pkg::byte_t     sd_buff_din,
	output logic               sd_ack,
	output logic               sd_buff_wr,
	output logic               img_readonly,
	output hps_pkg::buff_addr_t sd_buff_addr,
	output hps_pkg::byte_t     sd_buff_dout,
	output hps_pkg::vdisk_t    img_mounted,
	output logic [63:0]        img_size,
	output hps_pkg::word_t     rd_word
);

	import hps_pkg::*;

	word_t sd_status;
	logic  wr_req;

	// pending block requests as the host polls them
	assign sd_status = {
		4'b0000,
		sd_wr[1],
		2'b00,
		sd_rd[1],
		SD_CMD_ID,
		1'b0,
		1'b1,
		sd_wr[0],
		sd_rd[0]
	};

	//////////////////////////////
	// sector buffer port
	//////////////////////////////

	// write chain: strobe -> wr_req -> sd_buff_wr -> address step,
	// so the buffer write still sees the old address
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_req       <= 1'b0;
			sd_buff_wr   <= 1'b0;
			sd_buff_addr <= '0;
			sd_buff_dout <= '0;
			sd_ack       <= 1'b0;
		end else begin
			wr_req     <= 1'b0;
			sd_buff_wr <= wr_req;

			if (cmd_strobe) begin
				sd_buff_addr <= '0;
				if (cmd == CMD_SD_WRITE || cmd == CMD_SD_READ)
					sd_ack <= 1'b1;
			end else if (sd_buff_wr && !(&sd_buff_addr)) begin
				sd_buff_addr <= sd_buff_addr + 9'd1;
			end else if (data_strobe && cmd == CMD_SD_READ && !(&sd_buff_addr)) begin
				// read byte goes out now, next one is fetched meanwhile
				sd_buff_addr <= sd_buff_addr + 9'd1;
			end

			if (data_strobe && cmd == CMD_SD_WRITE) begin
				sd_buff_dout <= io_din[7:0];
				wr_req       <= 1'b1;
			end

			if (frame_end)
				sd_ack <= 1'b0;
		end
	end

	//////////////////////////////
	// image info and readback
	//////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			img_mounted  <= '0;
			img_readonly <= 1'b0;
			img_size     <= '0;
			rd_word      <= '0;
		end else begin
			if (cmd_strobe || data_strobe || frame_end)
				rd_word <= '0;

			// mount flags last until the next command
			if (cmd_strobe)
				img_mounted <= '0;

			if (data_strobe) begin
				case (cmd)
					CMD_SD_STATUS: begin
						case (word_idx)
							10'd1: rd_word <= sd_status;
							10'd2: rd_word <= sd_lba[15:0];
							10'd3: rd_word <= sd_lba[31:16];
							10'd4: rd_word <= sd_req_type;
							default: ;
						endcase
					end
					CMD_SD_READ: rd_word <= {8'h00, sd_buff_din};
					CMD_IMG_MOUNT: begin
						if (word_idx == 10'd1) begin
							// no disk bits means disk 0
							img_mounted  <= (io_din[1:0] != 2'b00) ? io_din[1:0] : 2'b01;
							img_readonly <= io_din[7];
						end
					end
					CMD_IMG_SIZE: begin
						case (word_idx)
							10'd1: img_size[15:0]  <= io_din;
							10'd2: img_size[31:16] <= io_din;
							10'd3: img_size[47:32] <= io_din;
							10'd4: img_size[63:48] <= io_din;
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: file_download.sv
/* file download port */

`default_nettype none

module file_download (
	input  logic               clk_sys,
	input  logic               reset,
	input  hps_pkg::word_t     cmd,
	input  hps_pkg::word_idx_t word_idx,
	input  logic               data_strobe,
	input  hps_pkg::word_t     io_din,
	output logic               ioctl_download,
	output logic               ioctl_wr,
	output hps_pkg::byte_t     ioctl_index,
	output hps_pkg::dl_addr_t  ioctl_addr,
	output hps_pkg::byte_t     ioctl_dout,
	output logic [31:0]        ioctl_file_ext
);

	import hps_pkg::*;

	dl_addr_t addr;
	logic     wr_req;

	// address and data settle one cycle ahead of the write pulse
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			addr           <= '0;
			wr_req         <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
		end else begin
			wr_req   <= 1'b0;
			ioctl_wr <= wr_req;

			if (data_strobe) begin
				case (cmd)
					CMD_FILE_INFO: begin
						if (word_idx == 10'd1)
							ioctl_file_ext[31:16] <= io_din;
						else if (word_idx == 10'd2)
							ioctl_file_ext[15:0] <= io_din;
					end
					CMD_FILE_INDEX: ioctl_index <= io_din[7:0];
					CMD_FILE_TX: begin
						if (io_din[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// byte count is left on the address
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= io_din[7:0];
						wr_req     <= 1'b1;
						addr       <= addr + 27'd1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hps_io_top.sv
/* host command port top */

`default_nettype none

module hps_io_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                io_enable,
	input  logic                io_strobe,
	input  hps_pkg::word_t      io_din,
	output hps_pkg::word_t      io_dout,
	input  hps_pkg::word_t      joy_raw,
	input  logic [31:0]         status_in,
	input  logic                status_set,
	input  hps_pkg::word_t      status_menumask,
	output logic [31:0]         joystick_0,
	output logic [31:0]         joystick_1,
	output logic [31:0]         status,
	output logic [1:0]          buttons,
	output logic                forced_scandoubler,
	input  logic [31:0]         sd_lba,
	input  hps_pkg::vdisk_t     sd_rd,
	input  hps_pkg::vdisk_t     sd_wr,
	input  hps_pkg::word_t      sd_req_type,
	input  hps_pkg::byte_t      sd_buff_din,
	output logic                sd_ack,
	output logic                sd_buff_wr,
	output logic                img_readonly,
	output hps_pkg::buff_addr_t sd_buff_addr,
	output hps_pkg::byte_t      sd_buff_dout,
	output hps_pkg::vdisk_t     img_mounted,
	output logic [63:0]         img_size,
	output logic                ioctl_download,
	output logic                ioctl_wr,
	output hps_pkg::byte_t      ioctl_index,
	output hps_pkg::dl_addr_t   ioctl_addr,
	output hps_pkg::byte_t      ioctl_dout,
	output logic [31:0]         ioctl_file_ext
);

	import hps_pkg::*;

	word_t     cmd;
	word_idx_t word_idx;
	logic      cmd_strobe;
	logic      data_strobe;
	logic      frame_end;
	word_t     user_rd_word;
	word_t     sd_rd_word;

	// only the owning decoder returns a nonzero word
	assign io_dout = user_rd_word | sd_rd_word;

	hps_frame u_frame (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_enable   (io_enable),
		.io_strobe   (io_strobe),
		.io_din      (io_din),
		.cmd         (cmd),
		.word_idx    (word_idx),
		.cmd_strobe  (cmd_strobe),
		.data_strobe (data_strobe),
		.frame_end   (frame_end)
	);

	user_io_regs u_user (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.cmd_strobe         (cmd_strobe),
		.data_strobe        (data_strobe),
		.frame_end          (frame_end),
		.io_din             (io_din),
		.joy_raw            (joy_raw),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.rd_word            (user_rd_word)
	);

	sd_block_io u_sd (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cmd          (cmd),
		.word_idx     (word_idx),
		.cmd_strobe   (cmd_strobe),
		.data_strobe  (data_strobe),
		.frame_end    (frame_end),
		.io_din       (io_din),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_req_type  (sd_req_type),
		.sd_buff_din  (sd_buff_din),
		.sd_ack       (sd_ack),
		.sd_buff_wr   (sd_buff_wr),
		.img_readonly (img_readonly),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.rd_word      (sd_rd_word)
	);

	// download has no readback word
	file_download u_download (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cmd            (cmd),
		.word_idx       (word_idx),
		.data_strobe    (data_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

`default_nettype wire

// File: tb_hps_io.sv
/* host command port testbench */

`default_nettype none

module tb_hps_io;

	timeunit 1ns;
	timeprecision 1ns;

	import hps_pkg::*;

	localparam int SECTOR_BYTES = 24;
	localparam int DL_BYTES     = 16;
	localparam int WAIT_LIMIT   = 100;

	logic                clk_sys;
	logic                reset;
	logic                io_enable;
	logic                io_strobe;
	word_t               io_din;
	word_t               io_dout;
	word_t               joy_raw;
	logic [31:0]         status_in;
	logic                status_set;
	word_t               status_menumask;
	logic [31:0]         joystick_0;
	logic [31:0]         joystick_1;
	logic [31:0]         status;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic [31:0]         sd_lba;
	vdisk_t              sd_rd;
	vdisk_t              sd_wr;
	word_t               sd_req_type;
	byte_t               sd_buff_din = '0;
	logic                sd_ack;
	logic                sd_buff_wr;
	logic                img_readonly;
	buff_addr_t          sd_buff_addr;
	byte_t               sd_buff_dout;
	vdisk_t              img_mounted;
	logic [63:0]         img_size;
	logic                ioctl_download;
	logic                ioctl_wr;
	byte_t               ioctl_index;
	dl_addr_t            ioctl_addr;
	byte_t               ioctl_dout;
	logic [31:0]         ioctl_file_ext;

	int n_checks   = 0;
	int n_errors   = 0;
	int n_timeouts = 0;

	// pulses seen on the two write ports
	buff_addr_t sd_addr_q[$];
	byte_t      sd_data_q[$];
	dl_addr_t   dl_addr_q[$];
	byte_t      dl_data_q[$];

	hps_io_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// sector buffer model and monitors
	//////////////////////////////

	// buffer contents as a function of the full address
	function automatic byte_t buff_pattern(input buff_addr_t a);
		return a[7:0] ^ {a[8], 7'h35};
	endfunction

	// synchronous read that lags the address by one cycle
	always @(posedge clk_sys)
		sd_buff_din <= buff_pattern(sd_buff_addr);

	always @(posedge clk_sys) begin
		if (sd_buff_wr) begin
			sd_addr_q.push_back(sd_buff_addr);
			sd_data_q.push_back(sd_buff_dout);
		end
		if (ioctl_wr) begin
			dl_addr_q.push_back(ioctl_addr);
			dl_data_q.push_back(ioctl_dout);
		end
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic word_check(input string name, input word_t got, input word_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic byte_check(input string name, input byte_t got, input byte_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic u32_check(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	//////////////////////////////
	// bus tasks
	//////////////////////////////

	// strobe for one cycle, then hold off so strobes stay 4+ cycles apart
	task automatic start_frame(input word_t code, output word_t rd);
		@(posedge clk_sys);
		io_enable <= 1'b1;
		io_strobe <= 1'b1;
		io_din    <= code;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rd = io_dout;
	endtask

	task automatic send_word(input word_t data, output word_t rd);
		@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din    <= data;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rd = io_dout;
	endtask

	task automatic end_frame;
		@(posedge clk_sys);
		io_enable <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic two_word_write(input word_t code, input logic [31:0] val);
		word_t rd;
		start_frame(code, rd);
		send_word(val[15:0], rd);
		send_word(val[31:16], rd);
		end_frame();
	endtask

	task automatic ack_level_wait(input logic level);
		int cycles;
		cycles = 0;
		while (sd_ack !== level && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (sd_ack !== level) begin
			n_timeouts++;
			$display("timeout at %0t ns: sd_ack never went to %b", $time, level);
		end
	endtask

	task automatic sd_write_count_wait(input int n);
		int cycles;
		cycles = 0;
		while (sd_data_q.size() < n && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (sd_data_q.size() < n) begin
			n_timeouts++;
			$display("timeout: only %0d of %0d buffer writes seen", sd_data_q.size(), n);
		end
	endtask

	task automatic dl_write_count_wait(input int n);
		int cycles;
		cycles = 0;
		while (dl_data_q.size() < n && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (dl_data_q.size() < n) begin
			n_timeouts++;
			$display("timeout: only %0d of %0d download writes seen", dl_data_q.size(), n);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic reset_values;
		u32_check("sd_ack", 32'(sd_ack), 32'h0);
		u32_check("sd_buff_wr", 32'(sd_buff_wr), 32'h0);
		u32_check("ioctl_download", 32'(ioctl_download), 32'h0);
		u32_check("ioctl_wr", 32'(ioctl_wr), 32'h0);
		u32_check("img_mounted", 32'(img_mounted), 32'h0);
		word_check("io_dout", io_dout, 16'h0000);
		u32_check("joystick_0", joystick_0, 32'h0);
		u32_check("status", status, 32'h0);
	endtask

	task automatic user_registers;
		logic [31:0] val;
		byte_t       cfg;
		word_t       rd;
		val = $urandom;
		two_word_write(CMD_JOY0, val);
		u32_check("joystick_0", joystick_0, val);
		val = $urandom;
		two_word_write(CMD_JOY1, val);
		u32_check("joystick_1", joystick_1, val);
		val = $urandom;
		two_word_write(CMD_STATUS, val);
		u32_check("status", status, val);

		cfg = byte_t'($urandom);
		start_frame(CMD_CFG, rd);
		send_word({8'h00, cfg}, rd);
		end_frame();
		u32_check("buttons", 32'(buttons), 32'(cfg[1:0]));
		u32_check("forced_scandoubler", 32'(forced_scandoubler), 32'(cfg[4]));

		@(posedge clk_sys);
		joy_raw         <= word_t'($urandom);
		status_menumask <= word_t'($urandom);
		start_frame(CMD_JOY_RAW, rd);
		send_word(16'h0000, rd);
		word_check("io_dout joy_raw", rd, joy_raw);
		end_frame();
		start_frame(CMD_MENUMASK, rd);
		send_word(16'h0000, rd);
		word_check("io_dout menumask", rd, status_menumask);
		end_frame();
	endtask

	task automatic status_request;
		logic [31:0] last;
		word_t       rd;
		last = '0;
		for (int k = 0; k < 3; k++) begin
			last = $urandom;
			@(posedge clk_sys);
			status_in  <= last;
			status_set <= 1'b1;
			repeat (2) @(posedge clk_sys);
			status_set <= 1'b0;
			repeat (3) @(posedge clk_sys);
		end
		// tag Ah over a count of three requests
		start_frame(CMD_STATUS_SET, rd);
		word_check("io_dout status-set reply", rd, 16'h00A3);
		send_word(16'h0000, rd);
		word_check("io_dout status_in low", rd, last[15:0]);
		send_word(16'h0000, rd);
		word_check("io_dout status_in high", rd, last[31:16]);
		end_frame();
	endtask

	task automatic mount_image(input word_t val, input vdisk_t exp_mnt, input logic exp_ro);
		word_t rd;
		start_frame(CMD_IMG_MOUNT, rd);
		send_word(val, rd);
		end_frame();
		u32_check("img_mounted", 32'(img_mounted), 32'(exp_mnt));
		u32_check("img_readonly", 32'(img_readonly), 32'(exp_ro));
	endtask

	task automatic sd_status_and_mount;
		logic [31:0] lba;
		word_t       req;
		word_t       exp_stat;
		logic [63:0] size;
		word_t       rd;
		lba = $urandom;
		req = word_t'($urandom);
		@(posedge clk_sys);
		sd_rd       <= 2'b10;
		sd_wr       <= 2'b00;
		sd_lba      <= lba;
		sd_req_type <= req;
		// read request of disk 1, fixed id 5h and the constant one at bit 2
		exp_stat = 16'h0100 | 16'h0050 | 16'h0004;
		start_frame(CMD_SD_STATUS, rd);
		send_word(16'h0000, rd);
		word_check("io_dout sd status", rd, exp_stat);
		send_word(16'h0000, rd);
		word_check("io_dout sd_lba low", rd, lba[15:0]);
		send_word(16'h0000, rd);
		word_check("io_dout sd_lba high", rd, lba[31:16]);
		send_word(16'h0000, rd);
		word_check("io_dout sd_req_type", rd, req);
		end_frame();
		@(posedge clk_sys);
		sd_rd <= 2'b00;

		mount_image(16'h0000, 2'b01, 1'b0);
		mount_image(16'h0082, 2'b10, 1'b1);

		size = {$urandom, $urandom};
		start_frame(CMD_IMG_SIZE, rd);
		for (int i = 0; i < 4; i++)
			send_word(size[16*i +: 16], rd);
		end_frame();
		u32_check("img_size low", img_size[31:0], size[31:0]);
		u32_check("img_size high", img_size[63:32], size[63:32]);
	endtask

	task automatic sector_write;
		byte_t data[SECTOR_BYTES];
		word_t rd;
		sd_addr_q.delete();
		sd_data_q.delete();
		start_frame(CMD_SD_WRITE, rd);
		ack_level_wait(1'b1);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			data[i] = byte_t'($urandom);
			// high byte is noise, only the low byte is stored
			send_word({byte_t'($urandom), data[i]}, rd);
		end
		sd_write_count_wait(SECTOR_BYTES);
		end_frame();
		ack_level_wait(1'b0);
		u32_check("sd_buff_wr pulses", 32'(sd_data_q.size()), SECTOR_BYTES);
		for (int i = 0; i < SECTOR_BYTES && i < sd_data_q.size(); i++) begin
			u32_check("sd_buff_addr", 32'(sd_addr_q[i]), i);
			byte_check("sd_buff_dout", sd_data_q[i], data[i]);
		end
	endtask

	task automatic sector_read;
		word_t rd;
		start_frame(CMD_SD_READ, rd);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			send_word(16'h0000, rd);
			word_check("io_dout sector byte", rd, {8'h00, buff_pattern(9'(i))});
		end
		end_frame();
		ack_level_wait(1'b0);
	endtask

	task automatic download;
		byte_t       data[DL_BYTES];
		byte_t       idx;
		logic [31:0] ext;
		word_t       rd;
		idx = byte_t'($urandom);
		ext = $urandom;
		start_frame(CMD_FILE_INDEX, rd);
		send_word({8'h00, idx}, rd);
		end_frame();
		byte_check("ioctl_index", ioctl_index, idx);
		start_frame(CMD_FILE_INFO, rd);
		send_word(ext[31:16], rd);
		send_word(ext[15:0], rd);
		end_frame();
		u32_check("ioctl_file_ext", ioctl_file_ext, ext);

		dl_addr_q.delete();
		dl_data_q.delete();
		start_frame(CMD_FILE_TX, rd);
		send_word(16'h0001, rd);
		end_frame();
		u32_check("ioctl_download", 32'(ioctl_download), 32'h1);

		start_frame(CMD_FILE_TX_DAT, rd);
		for (int i = 0; i < DL_BYTES; i++) begin
			data[i] = byte_t'($urandom);
			send_word({8'h00, data[i]}, rd);
		end
		dl_write_count_wait(DL_BYTES);
		end_frame();
		u32_check("ioctl_wr pulses", 32'(dl_data_q.size()), DL_BYTES);
		for (int i = 0; i < DL_BYTES && i < dl_data_q.size(); i++) begin
			u32_check("ioctl_addr", 32'(dl_addr_q[i]), i);
			byte_check("ioctl_dout", dl_data_q[i], data[i]);
		end

		// zero low byte stops, high byte is ignored
		start_frame(CMD_FILE_TX, rd);
		send_word(16'hA500, rd);
		end_frame();
		u32_check("ioctl_download", 32'(ioctl_download), 32'h0);
		u32_check("ioctl_addr count", 32'(ioctl_addr), DL_BYTES);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		void'($urandom(32'h33c6));
		reset           = 1'b1;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		joy_raw         = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		sd_lba          = '0;
		sd_rd           = '0;
		sd_wr           = '0;
		sd_req_type     = '0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		reset_values();
		user_registers();
		status_request();
		sd_status_and_mount();
		sector_write();
		sector_read();
		download();

		$display("checks: %0d, wrong values: %0d, timeouts: %0d",
			n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hps_pkg.sv
hps_frame.sv
user_io_regs.sv
sd_block_io.sv
file_download.sv
hps_io_top.sv
tb_hps_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module tb_hps_io -f build.f \
	&& ./obj_dir/Vtb_hps_io | tee /dev/stderr | grep -qF '*** PASSED ***' \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }
